//--- logic/csr_map_pkg.sv
/*
  register map of the machine-mode CSR file
  - implemented CSR numbers and access operation codes
  - counter and event vector widths
  - writable interrupt enable bits, misa constant, mtvec reset mode
  - mstatus field positions
*/
`default_nettype none

package csr_map_pkg;

  // implemented machine-mode CSR numbers
  typedef enum logic [11:0] {
    CSR_MSTATUS            = 12'h300,
    CSR_MISA               = 12'h301,
    CSR_MIE                = 12'h304,
    CSR_MTVEC              = 12'h305,
    CSR_MCOUNTINHIBIT      = 12'h320,
    CSR_MHPMEVENT[3:31]    = 12'h323,  // 0x323 .. 0x33f
    CSR_MSCRATCH           = 12'h340,
    CSR_MEPC               = 12'h341,
    CSR_MCAUSE             = 12'h342,
    CSR_MIP                = 12'h344,
    CSR_MCYCLE             = 12'hB00,
    CSR_MINSTRET           = 12'hB02,
    CSR_MHPMCOUNTER[3:31]  = 12'hB03,  // low halves
    CSR_MCYCLEH            = 12'hB80,
    CSR_MINSTRETH          = 12'hB82,
    CSR_MHPMCOUNTERH[3:31] = 12'hB83,  // high halves
    CSR_MHARTID            = 12'hF14
  } csr_num_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  localparam int unsigned HPM_COUNTER_WIDTH = 64;
  localparam int unsigned NUM_HPM_EVENTS    = 16;

  // msi, mti, mei and the 16 platform lines
  localparam logic [31:0] IRQ_MASK = 32'hFFFF_0888;

  // RV32IM, mxl = 1
  localparam logic [31:0] MISA_VALUE = (32'd1 << 30) | (32'd1 << 12) | (32'd1 << 8);

  localparam logic [1:0] MTVEC_MODE_RESET = 2'b01;  // vectored

  // mstatus bit positions
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LSB  = 11;
  localparam int unsigned MSTATUS_MPP_MSB  = 12;

endpackage

`default_nettype wire

//--- logic/csr_layout_pkg.sv
/*
  register layouts shared by the CSR file modules
  - privilege level and the mstatus struct and union views
  - hardware performance monitor event vector
  - write strobe structs for trap registers and counters
  - trap request from the controller
*/
`default_nettype none

package csr_layout_pkg;

  import csr_map_pkg::*;

  typedef enum logic [1:0] {
    PRIV_LVL_M = 2'b11  // only level implemented
  } priv_lvl_e;

  // architectural mstatus, unlisted fields read zero
  typedef struct packed {
    logic [31:MSTATUS_MPP_MSB+1]                 rsv_hi;
    priv_lvl_e                                   mpp;
    logic [MSTATUS_MPP_LSB-1:MSTATUS_MPIE_BIT+1] rsv_mid;
    logic                                        mpie;
    logic [MSTATUS_MPIE_BIT-1:MSTATUS_MIE_BIT+1] rsv_lo;
    logic                                        mie;
    logic [MSTATUS_MIE_BIT-1:0]                  rsv_uie;
  } mstatus_t;

  // same word, seen as bus data or as fields
  typedef union packed {
    logic [31:0] raw;
    mstatus_t    fields;
  } mstatus_u;

  // event vector, bit 0 first
  typedef struct packed {
    logic [NUM_HPM_EVENTS-1:11] spare;         // tied to zero
    logic                       compressed;
    logic                       branch_taken;
    logic                       branch;
    logic                       jump;
    logic                       store;
    logic                       load;
    logic                       imiss;
    logic                       jr_stall;
    logic                       ld_stall;
    logic                       retire;
    logic                       cycle;         // always counts
  } hpm_event_t;

  // per slice strobes, write data travels beside
  typedef struct packed {
    logic wr_lo;
    logic wr_hi;
    logic wr_event;
    logic wr_inhibit;
    logic inhibit;     // new inhibit bit for this slice
  } hpm_wr_t;

  typedef struct packed {
    logic mstatus;
    logic mie;
    logic mtvec;
    logic mscratch;
    logic mepc;
    logic mcause;
  } trap_we_t;

  typedef struct packed {
    logic mcycle_lo;
    logic mcycle_hi;
    logic minstret_lo;
    logic minstret_hi;
    logic inhibit;
  } base_we_t;

  // controller side trap request
  typedef struct packed {
    logic        save_cause;
    logic        save_if;
    logic        save_id;
    logic        save_ex;
    logic [31:0] pc_if;
    logic [31:0] pc_id;
    logic [31:0] pc_ex;
    logic [5:0]  cause;   // bit 5 marks an interrupt
    logic        mret;
  } trap_ctrl_t;

endpackage

`default_nettype wire

//--- logic/csr_access_ctrl.sv
/*
  CSR access control
  - read, write, set and clear turned into one write value
  - CSR number decoded into strobes for trap registers,
    fixed counters and every programmable counter slice
*/
`timescale 1ns/1ns
`default_nettype none

module csr_access_ctrl
  import csr_map_pkg::*;
  import csr_layout_pkg::*;
#(
  parameter int unsigned NUM_HPM_COUNTERS = 2
) (
  input  csr_num_e                       csr_addr_i,
  input  csr_op_e                        csr_op_i,
  input  logic [31:0]                    csr_wdata_i,
  input  logic [31:0]                    rdata_i,     // current value of the addressed CSR
  output logic [31:0]                    wdata_o,
  output trap_we_t                       trap_we_o,
  output base_we_t                       base_we_o,
  output hpm_wr_t [NUM_HPM_COUNTERS-1:0] hpm_we_o
);

  logic        we;
  logic        inhibit_we;
  logic [11:0] addr;  // raw number for slice offsets

  assign addr = csr_addr_i;

  // read-modify-write
  always_comb begin
    we      = 1'b1;
    wdata_o = csr_wdata_i;
    case (csr_op_i)
      CSR_OP_SET:   wdata_o = csr_wdata_i | rdata_i;
      CSR_OP_CLEAR: wdata_o = ~csr_wdata_i & rdata_i;
      CSR_OP_READ:  we = 1'b0;
      default:      ;  // plain write
    endcase
  end

  ////////////////////////////////////////////////////////////
  // write decode

  assign trap_we_o.mstatus  = we && (csr_addr_i == CSR_MSTATUS);
  assign trap_we_o.mie      = we && (csr_addr_i == CSR_MIE);
  assign trap_we_o.mtvec    = we && (csr_addr_i == CSR_MTVEC);
  assign trap_we_o.mscratch = we && (csr_addr_i == CSR_MSCRATCH);
  assign trap_we_o.mepc     = we && (csr_addr_i == CSR_MEPC);
  assign trap_we_o.mcause   = we && (csr_addr_i == CSR_MCAUSE);

  assign inhibit_we = we && (csr_addr_i == CSR_MCOUNTINHIBIT);

  assign base_we_o.mcycle_lo   = we && (csr_addr_i == CSR_MCYCLE);
  assign base_we_o.mcycle_hi   = we && (csr_addr_i == CSR_MCYCLEH);
  assign base_we_o.minstret_lo = we && (csr_addr_i == CSR_MINSTRET);
  assign base_we_o.minstret_hi = we && (csr_addr_i == CSR_MINSTRETH);
  assign base_we_o.inhibit     = inhibit_we;

  // slice k serves counter number k+3
  always_comb begin
    for (int k = 0; k < NUM_HPM_COUNTERS; k++) begin
      hpm_we_o[k].wr_lo      = we && (addr == 12'(CSR_MHPMCOUNTER3 + k));
      hpm_we_o[k].wr_hi      = we && (addr == 12'(CSR_MHPMCOUNTERH3 + k));
      hpm_we_o[k].wr_event   = we && (addr == 12'(CSR_MHPMEVENT3 + k));
      hpm_we_o[k].wr_inhibit = inhibit_we;
      hpm_we_o[k].inhibit    = wdata_o[k+3];
    end
  end

endmodule

`default_nettype wire

//--- logic/trap_csr_regs.sv
/*
  machine trap registers
  - mstatus, mie, mtvec, mscratch, mepc, mcause
  - software writes with per-register field rules
  - trap entry and MRET, which win over a software write
  - same-cycle mie bypass and the global interrupt enable
*/
`timescale 1ns/1ns
`default_nettype none

module trap_csr_regs
  import csr_map_pkg::*;
  import csr_layout_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] wdata_i,
  input  trap_we_t    trap_we_i,
  input  trap_ctrl_t  trap_i,
  input  logic        mtvec_init_i,   // boot load of the vector base
  input  logic [31:0] mtvec_addr_i,
  output mstatus_u    mstatus_o,
  output logic [31:0] mie_o,
  output logic [23:0] mtvec_o,
  output logic [1:0]  mtvec_mode_o,
  output logic [31:0] mscratch_o,
  output logic [31:0] mepc_o,
  output logic [5:0]  mcause_o,
  output logic [31:0] mie_bypass_o,
  output logic        m_irq_enable_o
);

  mstatus_u    wr_view;   // write value as mstatus fields
  logic        mie_q;     // mstatus.mie
  logic        mpie_q;    // mstatus.mpie
  logic [31:0] exc_pc;

  assign wr_view.raw = wdata_i;

  // pc to save, id stage unless told otherwise
  always_comb begin
    exc_pc = trap_i.pc_id;
    if (trap_i.save_if) begin
      exc_pc = trap_i.pc_if;
    end else if (trap_i.save_ex) begin
      exc_pc = trap_i.pc_ex;
    end
  end

  ////////////////////////////////////////////////////////////
  // mstatus, save > mret > software write

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mie_q  <= 1'b0;
      mpie_q <= 1'b0;
    end else if (trap_i.save_cause) begin
      mpie_q <= mie_q;   // stack the enable
      mie_q  <= 1'b0;
    end else if (trap_i.mret) begin
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
    end else if (trap_we_i.mstatus) begin
      mie_q  <= wr_view.fields.mie;
      mpie_q <= wr_view.fields.mpie;
    end
  end

  // mpp stays at machine level
  always_comb begin
    mstatus_o.raw         = '0;
    mstatus_o.fields.mpp  = PRIV_LVL_M;
    mstatus_o.fields.mpie = mpie_q;
    mstatus_o.fields.mie  = mie_q;
  end

  ////////////////////////////////////////////////////////////
  // remaining trap registers

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mepc_o       <= '0;
      mcause_o     <= '0;
      mie_o        <= '0;
      mscratch_o   <= '0;
      mtvec_o      <= '0;
      mtvec_mode_o <= MTVEC_MODE_RESET;
    end else begin
      if (trap_i.save_cause) begin
        mepc_o   <= exc_pc;
        mcause_o <= trap_i.cause;
      end else begin
        if (trap_we_i.mepc)   mepc_o   <= wdata_i & ~32'd1;  // halfword aligned
        if (trap_we_i.mcause) mcause_o <= {wdata_i[31], wdata_i[4:0]};
      end
      if (trap_we_i.mie)      mie_o      <= wdata_i & IRQ_MASK;
      if (trap_we_i.mscratch) mscratch_o <= wdata_i;
      if (trap_we_i.mtvec) begin
        mtvec_o      <= wdata_i[31:8];
        mtvec_mode_o <= {1'b0, wdata_i[0]};  // direct or vectored only
      end else if (mtvec_init_i) begin
        mtvec_o <= mtvec_addr_i[31:8];
      end
    end
  end

  // new mie seen by the very next instruction
  assign mie_bypass_o   = trap_we_i.mie ? (wdata_i & IRQ_MASK) : mie_o;
  assign m_irq_enable_o = mie_q;

endmodule

`default_nettype wire

//--- logic/hpm_base_counters.sv
/*
  fixed performance counters
  - mcycle, counts every cycle
  - minstret, counts retire pulses
  - their two mcountinhibit bits
*/
`timescale 1ns/1ns
`default_nettype none

module hpm_base_counters
  import csr_map_pkg::*;
  import csr_layout_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [31:0]                  wdata_i,
  input  base_we_t                     base_we_i,
  input  hpm_event_t                   events_i,
  output logic [HPM_COUNTER_WIDTH-1:0] mcycle_o,
  output logic [HPM_COUNTER_WIDTH-1:0] minstret_o,
  output logic [1:0]                   inhibit_o    // {minstret, mcycle}
);

  logic [1:0][HPM_COUNTER_WIDTH-1:0] cnt_q;   // index 0 mcycle, 1 minstret
  logic [1:0]                        wr_lo;
  logic [1:0]                        wr_hi;
  logic [1:0]                        inc;

  assign wr_lo = {base_we_i.minstret_lo, base_we_i.mcycle_lo};
  assign wr_hi = {base_we_i.minstret_hi, base_we_i.mcycle_hi};
  assign inc   = ~inhibit_o & {events_i.retire, 1'b1};

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q     <= '0;
      inhibit_o <= 2'b11;   // stopped out of reset
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (wr_lo[i]) begin
          cnt_q[i][31:0] <= wdata_i;
        end else if (wr_hi[i]) begin
          cnt_q[i][HPM_COUNTER_WIDTH-1:32] <= wdata_i;
        end else if (inc[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
      if (base_we_i.inhibit) inhibit_o <= {wdata_i[2], wdata_i[0]};  // bit 1 unused
    end
  end

  assign mcycle_o   = cnt_q[0];
  assign minstret_o = cnt_q[1];

endmodule

`default_nettype wire

//--- logic/hpm_counter.sv
/*
  one programmable performance counter slice
  - 16-bit event selector (mhpmevent)
  - inhibit bit from mcountinhibit
  - 64-bit counter, written by halves
*/
`timescale 1ns/1ns
`default_nettype none

module hpm_counter
  import csr_map_pkg::*;
  import csr_layout_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [31:0]                  wdata_i,
  input  hpm_wr_t                      wr_i,
  input  hpm_event_t                   events_i,
  output logic [HPM_COUNTER_WIDTH-1:0] count_o,
  output logic [31:0]                  event_sel_o,
  output logic                         inhibit_o
);

  logic [NUM_HPM_EVENTS-1:0] sel_q;
  hpm_event_t                ev;
  logic                      hit;

  // cycle is always active, spare lines never
  always_comb begin
    ev       = events_i;
    ev.cycle = 1'b1;
    ev.spare = '0;
  end

  assign hit = |(ev & sel_q);  // any selected event

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      sel_q     <= '0;
      inhibit_o <= 1'b1;
      count_o   <= '0;
    end else begin
      if (wr_i.wr_event)   sel_q     <= wdata_i[NUM_HPM_EVENTS-1:0];
      if (wr_i.wr_inhibit) inhibit_o <= wr_i.inhibit;
      if (wr_i.wr_lo) begin
        count_o[31:0] <= wdata_i;
      end else if (wr_i.wr_hi) begin
        count_o[HPM_COUNTER_WIDTH-1:32] <= wdata_i;
      end else if (!inhibit_o && hit) begin
        count_o <= count_o + 1'b1;
      end
    end
  end

  assign event_sel_o = {{(32 - NUM_HPM_EVENTS){1'b0}}, sel_q};

endmodule

`default_nettype wire

//--- logic/csr_read_mux.sv
/*
  CSR read data select
  - trap registers, identity constants, mip
  - fixed and programmable counters by halves, event selectors
  - mcountinhibit rebuilt from the per-counter bits
*/
`timescale 1ns/1ns
`default_nettype none

module csr_read_mux
  import csr_map_pkg::*;
  import csr_layout_pkg::*;
#(
  parameter int unsigned NUM_HPM_COUNTERS = 2
) (
  input  csr_num_e                                          csr_addr_i,
  input  logic [31:0]                                       hart_id_i,
  input  logic [31:0]                                       mip_i,
  input  mstatus_u                                          mstatus_i,
  input  logic [31:0]                                       mie_i,
  input  logic [23:0]                                       mtvec_i,
  input  logic [1:0]                                        mtvec_mode_i,
  input  logic [31:0]                                       mscratch_i,
  input  logic [31:0]                                       mepc_i,
  input  logic [5:0]                                        mcause_i,
  input  logic [HPM_COUNTER_WIDTH-1:0]                      mcycle_i,
  input  logic [HPM_COUNTER_WIDTH-1:0]                      minstret_i,
  input  logic [1:0]                                        base_inhibit_i,
  input  logic [NUM_HPM_COUNTERS-1:0][HPM_COUNTER_WIDTH-1:0] hpm_count_i,
  input  logic [NUM_HPM_COUNTERS-1:0][31:0]                 hpm_event_i,
  input  logic [NUM_HPM_COUNTERS-1:0]                       hpm_inhibit_i,
  output logic [31:0]                                       rdata_o
);

  logic [31:0] inhibit_word;
  logic [11:0] addr;

  assign addr = csr_addr_i;

  always_comb begin
    inhibit_word                        = '0;   // bit 1 has no counter
    inhibit_word[0]                     = base_inhibit_i[0];
    inhibit_word[2]                     = base_inhibit_i[1];
    inhibit_word[NUM_HPM_COUNTERS+2:3]  = hpm_inhibit_i;
  end

  always_comb begin
    rdata_o = '0;
    case (csr_addr_i)
      CSR_MSTATUS:       rdata_o = mstatus_i.raw;
      CSR_MISA:          rdata_o = MISA_VALUE;
      CSR_MIE:           rdata_o = mie_i;
      CSR_MTVEC:         rdata_o = {mtvec_i, 6'b0, mtvec_mode_i};
      CSR_MSCRATCH:      rdata_o = mscratch_i;
      CSR_MEPC:          rdata_o = mepc_i;
      CSR_MCAUSE:        rdata_o = {mcause_i[5], 26'b0, mcause_i[4:0]};  // irq flag on top
      CSR_MIP:           rdata_o = mip_i;
      CSR_MHARTID:       rdata_o = hart_id_i;
      CSR_MCOUNTINHIBIT: rdata_o = inhibit_word;
      CSR_MCYCLE:        rdata_o = mcycle_i[31:0];
      CSR_MCYCLEH:       rdata_o = mcycle_i[HPM_COUNTER_WIDTH-1:32];
      CSR_MINSTRET:      rdata_o = minstret_i[31:0];
      CSR_MINSTRETH:     rdata_o = minstret_i[HPM_COUNTER_WIDTH-1:32];
      default: begin
        // programmable slices, unimplemented numbers stay zero
        for (int k = 0; k < NUM_HPM_COUNTERS; k++) begin
          if (addr == 12'(CSR_MHPMCOUNTER3 + k))  rdata_o = hpm_count_i[k][31:0];
          if (addr == 12'(CSR_MHPMCOUNTERH3 + k)) rdata_o = hpm_count_i[k][HPM_COUNTER_WIDTH-1:32];
          if (addr == 12'(CSR_MHPMEVENT3 + k))    rdata_o = hpm_event_i[k];
        end
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/csr_file.sv
/*
  machine-mode CSR file of the RV32 core
  - access control, trap registers, fixed counters, read select
  - gen_hpm array of programmable counters
*/
`timescale 1ns/1ns
`default_nettype none

module csr_file
  import csr_map_pkg::*;
  import csr_layout_pkg::*;
#(
  parameter int unsigned NUM_HPM_COUNTERS = 2  // 1 .. 29
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] hart_id_i,
  input  csr_num_e    csr_addr_i,
  input  csr_op_e     csr_op_i,
  input  logic [31:0] csr_wdata_i,
  output logic [31:0] csr_rdata_o,
  input  logic [31:0] mip_i,
  input  trap_ctrl_t  trap_i,
  input  logic        mtvec_init_i,
  input  logic [31:0] mtvec_addr_i,
  input  hpm_event_t  events_i,
  output logic [31:0] mie_bypass_o,
  output logic        m_irq_enable_o,
  output logic [23:0] mtvec_o,
  output logic [1:0]  mtvec_mode_o,
  output logic [31:0] mepc_o
);

  logic [31:0]                                        wdata;
  trap_we_t                                           trap_we;
  base_we_t                                           base_we;
  hpm_wr_t  [NUM_HPM_COUNTERS-1:0]                    hpm_we;
  mstatus_u                                           mstatus;
  logic [31:0]                                        mie;
  logic [31:0]                                        mscratch;
  logic [5:0]                                         mcause;
  logic [HPM_COUNTER_WIDTH-1:0]                       mcycle;
  logic [HPM_COUNTER_WIDTH-1:0]                       minstret;
  logic [1:0]                                         base_inhibit;
  logic [NUM_HPM_COUNTERS-1:0][HPM_COUNTER_WIDTH-1:0] hpm_count;
  logic [NUM_HPM_COUNTERS-1:0][31:0]                  hpm_event;
  logic [NUM_HPM_COUNTERS-1:0]                        hpm_inhibit;

  csr_access_ctrl #(
    .NUM_HPM_COUNTERS (NUM_HPM_COUNTERS)
  ) u_access (
    .csr_addr_i  (csr_addr_i),
    .csr_op_i    (csr_op_i),
    .csr_wdata_i (csr_wdata_i),
    .rdata_i     (csr_rdata_o),   // old value for set and clear
    .wdata_o     (wdata),
    .trap_we_o   (trap_we),
    .base_we_o   (base_we),
    .hpm_we_o    (hpm_we)
  );

  trap_csr_regs u_trap (
    .clk            (clk),
    .rst_n          (rst_n),
    .wdata_i        (wdata),
    .trap_we_i      (trap_we),
    .trap_i         (trap_i),
    .mtvec_init_i   (mtvec_init_i),
    .mtvec_addr_i   (mtvec_addr_i),
    .mstatus_o      (mstatus),
    .mie_o          (mie),
    .mtvec_o        (mtvec_o),
    .mtvec_mode_o   (mtvec_mode_o),
    .mscratch_o     (mscratch),
    .mepc_o         (mepc_o),
    .mcause_o       (mcause),
    .mie_bypass_o   (mie_bypass_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  hpm_base_counters u_base (
    .clk        (clk),
    .rst_n      (rst_n),
    .wdata_i    (wdata),
    .base_we_i  (base_we),
    .events_i   (events_i),
    .mcycle_o   (mcycle),
    .minstret_o (minstret),
    .inhibit_o  (base_inhibit)
  );

  ////////////////////////////////////////////////////////////
  // programmable counters, slice k is mhpmcounter(k+3)

  for (genvar k = 0; k < NUM_HPM_COUNTERS; k++) begin : gen_hpm
    hpm_counter u_cnt (
      .clk         (clk),
      .rst_n       (rst_n),
      .wdata_i     (wdata),
      .wr_i        (hpm_we[k]),
      .events_i    (events_i),
      .count_o     (hpm_count[k]),
      .event_sel_o (hpm_event[k]),
      .inhibit_o   (hpm_inhibit[k])
    );
  end

  csr_read_mux #(
    .NUM_HPM_COUNTERS (NUM_HPM_COUNTERS)
  ) u_rmux (
    .csr_addr_i     (csr_addr_i),
    .hart_id_i      (hart_id_i),
    .mip_i          (mip_i),
    .mstatus_i      (mstatus),
    .mie_i          (mie),
    .mtvec_i        (mtvec_o),
    .mtvec_mode_i   (mtvec_mode_o),
    .mscratch_i     (mscratch),
    .mepc_i         (mepc_o),
    .mcause_i       (mcause),
    .mcycle_i       (mcycle),
    .minstret_i     (minstret),
    .base_inhibit_i (base_inhibit),
    .hpm_count_i    (hpm_count),
    .hpm_event_i    (hpm_event),
    .hpm_inhibit_i  (hpm_inhibit),
    .rdata_o        (csr_rdata_o)
  );

endmodule

`default_nettype wire

//--- verification/csr_file_tb.sv
/*
  testbench of the machine-mode CSR file
  - clock, reset and falling-edge stimulus
  - expected values for trap registers and counters
  - immediate assertions and a watchdog
*/
`timescale 1ns/1ns
`default_nettype none

module csr_file_tb
  import csr_map_pkg::*;
  import csr_layout_pkg::*;
();

  localparam int unsigned CLK_PERIOD   = 4;
  localparam int unsigned RESET_CYCLES = 2;
  localparam int unsigned RAND_OPS     = 8;
  localparam int unsigned GAP_CYCLES   = 10;
  localparam int unsigned EVENT_CYCLES = 40;
  // rough cycle count of each test, summed
  localparam int unsigned TEST_CYCLES  = RESET_CYCLES + 12        // reset values
                                       + 2 * RAND_OPS + 8        // operations
                                       + 12                      // field rules
                                       + 4 * 8 + 4               // trap and return
                                       + GAP_CYCLES + EVENT_CYCLES + 16;
  localparam int unsigned WATCHDOG_NS  = 2 * TEST_CYCLES * CLK_PERIOD;  // 2x margin

  localparam logic [31:0] MIE_WRITABLE = 32'hFFFF_0888;  // bits 3, 7, 11, 16..31
  localparam logic [31:0] MPP_M        = 32'h0000_1800;  // mpp = 3
  localparam logic [31:0] MIE_BIT      = 32'h0000_0008;
  localparam logic [31:0] MPIE_BIT     = 32'h0000_0080;

  logic        clk;
  logic        rst_n;
  logic [31:0] hart_id;
  csr_num_e    csr_addr;
  csr_op_e     csr_op;
  logic [31:0] csr_wdata;
  logic [31:0] csr_rdata;
  logic [31:0] mip;
  trap_ctrl_t  trap;
  logic        mtvec_init;
  logic [31:0] mtvec_addr;
  hpm_event_t  events;
  logic [31:0] mie_bypass;
  logic        m_irq_enable;
  logic [23:0] mtvec;
  logic [1:0]  mtvec_mode;
  logic [31:0] mepc;
  string       test_name;

  csr_file #(
    .NUM_HPM_COUNTERS (2)
  ) u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .hart_id_i      (hart_id),
    .csr_addr_i     (csr_addr),
    .csr_op_i       (csr_op),
    .csr_wdata_i    (csr_wdata),
    .csr_rdata_o    (csr_rdata),
    .mip_i          (mip),
    .trap_i         (trap),
    .mtvec_init_i   (mtvec_init),
    .mtvec_addr_i   (mtvec_addr),
    .events_i       (events),
    .mie_bypass_o   (mie_bypass),
    .m_irq_enable_o (m_irq_enable),
    .mtvec_o        (mtvec),
    .mtvec_mode_o   (mtvec_mode),
    .mepc_o         (mepc)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic check_value(input string what, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      $display("Mismatch in %s (%s): expected %h actual %h", test_name, what, exp_val, act_val);
      $display("ERRORS FOUND");
      $fatal(1, "first error, run stopped");
    end
  endtask

  // one access, lands on the rising edge in between
  task automatic access(input csr_num_e num, input csr_op_e op, input logic [31:0] data);
    csr_addr  = num;
    csr_op    = op;
    csr_wdata = data;
    @(negedge clk);
    csr_op = CSR_OP_READ;
  endtask

  // read op, compared at the next falling edge
  task automatic expect_csr(input csr_num_e num, input logic [31:0] exp_val,
                            input string what);
    csr_addr = num;
    csr_op   = CSR_OP_READ;
    @(negedge clk);
    check_value(what, exp_val, csr_rdata);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    logic [31:0] data;
    logic [31:0] model;
    logic [31:0] exp_pc;
    logic [31:0] exp_cause;
    logic [31:0] cycle_start;
    csr_op_e     op;
    hpm_event_t  sel;
    int unsigned n_ret;
    int unsigned n_ls;

    void'($urandom(73964));
    clk        = 1'b0;
    rst_n      = 1'b0;
    hart_id    = $urandom();
    csr_addr   = CSR_MSTATUS;
    csr_op     = CSR_OP_READ;
    csr_wdata  = '0;
    mip        = $urandom();
    trap       = '0;
    mtvec_init = 1'b0;
    mtvec_addr = '0;
    events     = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    test_name = "reset values";
    expect_csr(CSR_MSTATUS, MPP_M, "mstatus");
    expect_csr(CSR_MISA, 32'h4000_1100, "misa");  // mxl 1, I and M
    expect_csr(CSR_MHARTID, hart_id, "mhartid");
    expect_csr(CSR_MIP, mip, "mip");
    expect_csr(CSR_MTVEC, 32'h1, "mtvec");  // vectored
    expect_csr(CSR_MCOUNTINHIBIT, 32'h1D, "mcountinhibit");  // bit 1 has no counter
    expect_csr(CSR_MCYCLE, 32'h0, "mcycle");
    expect_csr(CSR_MINSTRET, 32'h0, "minstret");
    expect_csr(CSR_MHPMCOUNTER3, 32'h0, "mhpmcounter3");
    check_value("irq enable", 32'h0, {31'b0, m_irq_enable});

    test_name = "operations";
    model = '0;
    for (int i = 0; i < RAND_OPS; i++) begin
      op   = csr_op_e'(2'($urandom_range(3, 1)));  // write, set or clear
      data = $urandom();
      access(CSR_MSCRATCH, op, data);
      case (op)
        CSR_OP_SET:   model = model | data;
        CSR_OP_CLEAR: model = model & ~data;
        default:      model = data;
      endcase
      expect_csr(CSR_MSCRATCH, model, "mscratch");
    end
    access(CSR_MSCRATCH, CSR_OP_READ, ~model);
    expect_csr(CSR_MSCRATCH, model, "mscratch after read op");
    // bypass ahead of the register, still before the edge
    data      = $urandom();
    csr_addr  = CSR_MIE;
    csr_op    = CSR_OP_WRITE;
    csr_wdata = data;
    #1;
    check_value("mie bypass", data & MIE_WRITABLE, mie_bypass);
    check_value("mie before edge", 32'h0, csr_rdata);
    @(negedge clk);
    csr_op = CSR_OP_READ;
    expect_csr(CSR_MIE, data & MIE_WRITABLE, "mie");

    test_name = "field rules";
    data = $urandom() | 32'h1;  // odd, so the cleared bit shows
    access(CSR_MEPC, CSR_OP_WRITE, data);
    expect_csr(CSR_MEPC, data & ~32'h1, "mepc");
    data = ($urandom() | 32'h2) & ~32'h1;  // mode 0 against reset 1, bit 1 dropped
    access(CSR_MTVEC, CSR_OP_WRITE, data);
    expect_csr(CSR_MTVEC, {data[31:8], 7'b0, data[0]}, "mtvec");
    mtvec_addr = $urandom();
    mtvec_init = 1'b1;   // base only, mode kept
    @(negedge clk);
    mtvec_init = 1'b0;
    expect_csr(CSR_MTVEC, {mtvec_addr[31:8], 7'b0, data[0]}, "mtvec init");
    check_value("mtvec port", {8'b0, mtvec_addr[31:8]}, {8'b0, mtvec});
    check_value("mtvec mode port", {31'b0, data[0]}, {30'b0, mtvec_mode});
    data = $urandom();
    access(CSR_MCAUSE, CSR_OP_WRITE, data);
    expect_csr(CSR_MCAUSE, {data[31], 26'b0, data[4:0]}, "mcause");
    data = $urandom();
    access(CSR_MSTATUS, CSR_OP_WRITE, data);
    expect_csr(CSR_MSTATUS, MPP_M | (data & (MIE_BIT | MPIE_BIT)), "mstatus");

    test_name = "trap and return";
    for (int src = 0; src < 4; src++) begin
      access(CSR_MSTATUS, CSR_OP_WRITE, MIE_BIT);
      check_value("irq enable set", 32'h1, {31'b0, m_irq_enable});
      trap.pc_if      = $urandom() & ~32'h3;
      trap.pc_id      = $urandom() & ~32'h3;
      trap.pc_ex      = $urandom() & ~32'h3;
      trap.cause      = 6'($urandom());
      trap.save_if    = (src == 0);
      trap.save_id    = (src == 1);
      trap.save_ex    = (src == 2);   // src 3 has no strobe, id pc
      trap.save_cause = 1'b1;
      exp_pc    = (src == 0) ? trap.pc_if : (src == 2) ? trap.pc_ex : trap.pc_id;
      exp_cause = {trap.cause[5], 26'b0, trap.cause[4:0]};
      access(CSR_MEPC, CSR_OP_WRITE, $urandom());  // loses to the save
      trap = '0;
      expect_csr(CSR_MEPC, exp_pc, "mepc saved");
      check_value("mepc port", exp_pc, mepc);
      expect_csr(CSR_MCAUSE, exp_cause, "mcause saved");
      expect_csr(CSR_MSTATUS, MPP_M | MPIE_BIT, "mstatus on entry");
      check_value("irq enable on entry", 32'h0, {31'b0, m_irq_enable});
      trap.mret = 1'b1;
      @(negedge clk);
      trap.mret = 1'b0;
      expect_csr(CSR_MSTATUS, MPP_M | MPIE_BIT | MIE_BIT, "mstatus after mret");
    end
    // mret with mpie clear, mie follows and mpie comes back
    access(CSR_MSTATUS, CSR_OP_WRITE, 32'h0);
    trap.mret = 1'b1;
    @(negedge clk);
    trap.mret = 1'b0;
    expect_csr(CSR_MSTATUS, MPP_M | MPIE_BIT, "mret with mpie clear");

    test_name = "fixed counters";
    sel       = '0;
    sel.load  = 1'b1;
    sel.store = 1'b1;
    access(CSR_MHPMEVENT3, CSR_OP_WRITE, {16'b0, sel});
    access(CSR_MHPMEVENT4, CSR_OP_WRITE, 32'h1);      // every cycle
    access(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'h10);  // slice 4 stays stopped
    csr_addr = CSR_MCYCLE;
    @(negedge clk);
    cycle_start = csr_rdata;
    repeat (GAP_CYCLES) @(negedge clk);
    check_value("mcycle distance", GAP_CYCLES, csr_rdata - cycle_start);
    n_ret = 0;
    n_ls  = 0;
    for (int i = 0; i < EVENT_CYCLES; i++) begin
      events       = hpm_event_t'(16'($urandom()));
      events.spare = '0;
      events.cycle = 1'b1;
      if (events.retire) n_ret++;
      if (events.load || events.store) n_ls++;
      @(negedge clk);
    end
    events = '0;
    expect_csr(CSR_MINSTRET, n_ret, "minstret");
    data = $urandom();
    access(CSR_MCYCLEH, CSR_OP_WRITE, data);
    expect_csr(CSR_MCYCLEH, data, "mcycleh");

    test_name = "programmable counters";
    expect_csr(CSR_MHPMCOUNTER3, n_ls, "mhpmcounter3");
    expect_csr(CSR_MHPMEVENT3, {16'b0, sel}, "mhpmevent3");
    expect_csr(CSR_MHPMCOUNTER4, 32'h0, "mhpmcounter4 inhibited");
    expect_csr(CSR_MHPMEVENT5, 32'h0, "mhpmevent5");
    expect_csr(CSR_MHPMCOUNTER5, 32'h0, "mhpmcounter5");
    expect_csr(CSR_MCOUNTINHIBIT, 32'h10, "mcountinhibit");

    $display("NO ERRORS");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- list.f
logic/csr_map_pkg.sv
logic/csr_layout_pkg.sv
logic/csr_access_ctrl.sv
logic/trap_csr_regs.sv
logic/hpm_base_counters.sv
logic/hpm_counter.sv
logic/csr_read_mux.sv
logic/csr_file.sv
verification/csr_file_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the CSR file testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module csr_file_tb -o csr_file_sim; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/csr_file_sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
